// ==== project.f ====
kbd_pkg.sv
audio_pkg.sv
ps2_rx.sv
key_decoder.sv
tone_stepper.sv
pitch_pwm.sv
synth_top.sv
synth_assert.sv
tb_synth.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tone sweeper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_synth -f project.f -o tb_synth_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_synth_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb_synth.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_synth;

    import audio_pkg::*;
    import kbd_pkg::*;

    localparam int CLK_HZ       = 1_000_000;
    localparam int STEP_TICKS   = 400;
    localparam int PS2_HALF     = 40;  // clk cycles per PS/2 clock phase
    localparam int FRAME_CYCLES = 11 * 2 * PS2_HALF;
    localparam int SWEEP        = 30 * STEP_TICKS; // 30 slow steps
    localparam int HW           = 1 << KEY_W;
    localparam int HS           = 1 << KEY_S;
    localparam int HR           = 1 << KEY_R;
    localparam int HE           = 1 << KEY_ENTER;

    typedef enum int {CHK_TONE, CHK_HELD, CHK_PERIOD, CHK_GAP} chk_e;

    typedef struct {
        string      name;
        int         len;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        bit         bad;      // Flip the parity bit of every byte in the row
        int         wait_cyc;
        chk_e       kind;
        int         want;
    } row_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       aud_sig;
    tone_t      tone;
    logic [3:0] held_keys;
    row_t       rows[$];
    int         cycles = 0;
    int         cycle_limit;
    integer     seed = 63;

    synth_top #(
        .CLK_HZ     (CLK_HZ),
        .STEP_TICKS (STEP_TICKS)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .aud_sig    (aud_sig),
        .tone       (tone),
        .held_keys  (held_keys)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Simulation hung: no result after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic void add_row(input string name, input int len, input logic [7:0] b0,
                                    input logic [7:0] b1, input logic [7:0] b2, input bit bad,
                                    input int wait_cyc, input chk_e kind, input int want);
        row_t row;
        row.name     = name;
        row.len      = len;
        row.b0       = b0;
        row.b1       = b1;
        row.b2       = b2;
        row.bad      = bad;
        row.wait_cyc = wait_cyc;
        row.kind     = kind;
        row.want     = want;
        rows.push_back(row);
    endfunction

    // One cycle, then a little past the edge
    task automatic step_clk();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step_clk();
    endtask

    task automatic send_byte(input logic [7:0] data, input bit bad);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad, data, 1'b0}; // Odd parity
        repeat (11) begin
            ps2_dat = bits[0];
            bits    = bits >> 1;
            idle(PS2_HALF);
            ps2_clk = 1'b0;
            idle(PS2_HALF);
            ps2_clk = 1'b1;
            step_clk(); // Data moves while the PS/2 clock is high
        end
    endtask

    // Skips a possibly partial first wave
    task automatic wave_period(output int period);
        logic prev;
        int   edges;
        prev   = aud_sig;
        edges  = 0;
        period = 0;
        while (edges < 3) begin
            step_clk();
            if (edges == 2) begin
                period++;
            end
            if (aud_sig && !prev) begin
                edges++;
            end
            prev = aud_sig;
        end
    endtask

    task automatic tone_gap(output int gap);
        tone_t prev;
        int    changes;
        prev    = tone;
        changes = 0;
        gap     = 0;
        while (changes < 2) begin
            step_clk();
            if (changes == 1) begin
                gap++;
            end
            if (tone != prev) begin
                changes++;
            end
            prev = tone;
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        row_t row;
        int   got;
        rst     = 1'b1;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        add_row("sweep_up", 0, 8'h00, 8'h00, 8'h00, 1'b0, SWEEP, CHK_TONE, TONE_MAX);
        add_row("top_period", 0, 8'h00, 8'h00, 8'h00, 1'b0, 0, CHK_PERIOD, CLK_HZ / 4192);
        add_row("sweep_down", 1, SC_S, 8'h00, 8'h00, 1'b0, SWEEP, CHK_TONE, 0);
        add_row("low_period", 0, 8'h00, 8'h00, 8'h00, 1'b0, 0, CHK_PERIOD, CLK_HZ / 262);
        add_row("release_s", 2, SC_BREAK, SC_S, 8'h00, 1'b0, 0, CHK_HELD, 0);
        add_row("rate_fast", 1, SC_R, 8'h00, 8'h00, 1'b0, 0, CHK_HELD, HR);
        add_row("press_w", 1, SC_W, 8'h00, 8'h00, 1'b0, 0, CHK_HELD, HW | HR);
        add_row("fast_gap", 0, 8'h00, 8'h00, 8'h00, 1'b0, 0, CHK_GAP, STEP_TICKS / 2);
        add_row("release_r", 2, SC_BREAK, SC_R, 8'h00, 1'b0, 0, CHK_HELD, HW);
        add_row("rate_slow", 1, SC_R, 8'h00, 8'h00, 1'b0, 0, CHK_HELD, HW | HR);
        add_row("slow_gap", 0, 8'h00, 8'h00, 8'h00, 1'b0, 0, CHK_GAP, STEP_TICKS);
        add_row("press_s", 1, SC_S, 8'h00, 8'h00, 1'b0, 0, CHK_HELD, HW | HS | HR);
        add_row("repeat_w", 1, SC_W, 8'h00, 8'h00, 1'b0, 0, CHK_HELD, HW | HS | HR);
        // Still going down, so the repeat left the direction alone
        add_row("still_down", 0, 8'h00, 8'h00, 8'h00, 1'b0, SWEEP, CHK_TONE, 0);
        add_row("release_w", 2, SC_BREAK, SC_W, 8'h00, 1'b0, 0, CHK_HELD, HS | HR);
        add_row("ext_w", 2, SC_EXTEND, SC_W, 8'h00, 1'b0, 0, CHK_HELD, HS | HR);
        add_row("climb_w", 1, SC_W, 8'h00, 8'h00, 1'b0, 4000, CHK_HELD, HW | HS | HR);
        add_row("ext_release_w", 3, SC_EXTEND, SC_BREAK, SC_W, 1'b0, 0, CHK_HELD, HW | HS | HR);
        add_row("release_s2", 2, SC_BREAK, SC_S, 8'h00, 1'b0, 0, CHK_HELD, HW | HR);
        add_row("fall_s", 1, SC_S, 8'h00, 8'h00, 1'b0, 0, CHK_HELD, HW | HS | HR);
        add_row("enter", 1, SC_ENTER, 8'h00, 8'h00, 1'b0, 0, CHK_TONE, 0);
        add_row("enter_climb", 0, 8'h00, 8'h00, 8'h00, 1'b0, 600, CHK_TONE, 1);
        add_row("release_s3", 2, SC_BREAK, SC_S, 8'h00, 1'b0, 0, CHK_HELD, HW | HR | HE);
        add_row("bad_parity_s", 1, SC_S, 8'h00, 8'h00, 1'b1, 0, CHK_HELD, HW | HR | HE);
        add_row("rise_on", 0, 8'h00, 8'h00, 8'h00, 1'b0, SWEEP, CHK_TONE, TONE_MAX);

        cycle_limit = 0;
        foreach (rows[r]) begin
            cycle_limit += rows[r].wait_cyc + 11 * FRAME_CYCLES;
        end
        cycle_limit = 2 * cycle_limit;

        idle(8);
        rst = 1'b0;
        foreach (rows[r]) begin
            row = rows[r];
            if (row.len > 0) begin
                idle(4 + ($random(seed) & 31)); // Filler between frames
                send_byte(row.b0, row.bad);
            end
            if (row.len > 1) begin
                send_byte(row.b1, row.bad);
            end
            if (row.len > 2) begin
                send_byte(row.b2, row.bad);
            end
            idle(row.wait_cyc);
            case (row.kind)
                CHK_TONE:   got = int'(tone);
                CHK_HELD:   got = int'(held_keys);
                CHK_PERIOD: wave_period(got);
                default:    tone_gap(got);
            endcase
            compare_value(row.name, row.want, got);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== synth_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module synth_assert (
    input logic             clk,
    input logic             rst,
    input audio_pkg::tone_t tone,
    input logic             aud_sig,
    input logic [3:0]       key_press
);

    import audio_pkg::*;

    assert property (@(posedge clk) disable iff (rst) tone <= tone_t'(TONE_MAX))
        else $error("tone index above the top note");

    assert property (@(posedge clk) rst |-> !aud_sig)
        else $error("audio output active during reset");

    // Press strobes are single cycle
    assert property (@(posedge clk) disable iff (rst) (key_press & $past(key_press)) == 4'b0)
        else $error("key press strobe high for two cycles");

    assert property (@(posedge clk) disable iff (rst)
        tone == tone_t'(0) || tone == $past(tone) ||
        tone == $past(tone) + tone_t'(1) || tone + tone_t'(1) == $past(tone))
        else $error("tone moved by more than one step");

endmodule

bind synth_top synth_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .tone      (tone),
    .aud_sig   (aud_sig),
    .key_press (key_press)
);

`default_nettype wire

// ==== synth_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module synth_top #(
    parameter int CLK_HZ     = 100_000_000,
    parameter int STEP_TICKS = 50_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ps2_clk,
    input  logic             ps2_dat,
    output logic             aud_sig,
    output audio_pkg::tone_t tone,
    output logic [3:0]       held_keys
);

    logic [7:0] byte_data;
    logic       byte_valid;
    logic [3:0] key_press;

    ps2_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    key_decoder u_dec (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .key_held   (held_keys), // Debug only
        .key_press  (key_press)
    );

    tone_stepper #(
        .STEP_TICKS (STEP_TICKS)
    ) u_step (
        .clk        (clk),
        .rst        (rst),
        .key_press  (key_press),
        .tone       (tone)
    );

    pitch_pwm #(
        .CLK_HZ     (CLK_HZ)
    ) u_pwm (
        .clk        (clk),
        .rst        (rst),
        .tone       (tone),
        .aud_sig    (aud_sig)
    );

endmodule

`default_nettype wire

// ==== pitch_pwm.sv ====
`timescale 1ns/1ns
`default_nettype none

module pitch_pwm #(
    parameter int CLK_HZ = 100_000_000
) (
    input  logic             clk,
    input  logic             rst,
    input  audio_pkg::tone_t tone,
    output logic             aud_sig
);

    import audio_pkg::*;

    localparam period_t PERIOD_RST = note_period(CLK_HZ, '0);

    period_t period_rom [0:TONE_MAX];
    period_t period_q;   // Looked-up period of the current note
    period_t cur_period; // Period of the wave cycle in progress
    period_t cnt;

    // Constant table, no divider in hardware
    for (genvar i = 0; i <= TONE_MAX; i++) begin : g_tab
        assign period_rom[i] = note_period(CLK_HZ, tone_t'(i));
    end

    always_ff @(posedge clk) begin
        if (tone <= tone_t'(TONE_MAX)) begin
            period_q <= period_rom[tone];
        end else begin
            period_q <= period_rom[TONE_MAX];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt        <= '0;
            cur_period <= PERIOD_RST;
            aud_sig    <= 1'b0;
        end else begin
            if (cnt >= cur_period - period_t'(1)) begin
                cnt        <= '0;
                cur_period <= period_q; // Switch pitch only at wrap
            end else begin
                cnt <= cnt + period_t'(1);
            end
            aud_sig <= (cnt < (cur_period >> 1)); // Half duty
        end
    end

endmodule

`default_nettype wire

// ==== tone_stepper.sv ====
`timescale 1ns/1ns
`default_nettype none

module tone_stepper #(
    parameter int STEP_TICKS = 50_000_000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [3:0]        key_press,
    output audio_pkg::tone_t  tone
);

    import audio_pkg::*;
    import kbd_pkg::*;

    localparam logic [31:0] HALF_LAST = 32'(STEP_TICKS / 2 - 1);

    logic [31:0] tick_cnt;
    logic        tick;
    logic        tick_odd;  // Every second tick makes the slow step
    logic        dir_down;
    logic        rate_fast;
    logic        step;

    assign tick = (tick_cnt == HALF_LAST);
    assign step = tick & (rate_fast | tick_odd);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt  <= '0;
            tick_odd  <= 1'b0;
            dir_down  <= 1'b0;
            rate_fast <= 1'b0;
            tone      <= '0;
        end else if (key_press[KEY_ENTER]) begin
            // Restart the sweep from C4
            tick_cnt  <= '0;
            tick_odd  <= 1'b0;
            dir_down  <= 1'b0;
            rate_fast <= 1'b0;
            tone      <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 32'd1;
            if (tick) begin
                tick_odd <= ~tick_odd;
            end
            if (key_press[KEY_W]) begin
                dir_down <= 1'b0;
            end else if (key_press[KEY_S]) begin
                dir_down <= 1'b1;
            end
            if (key_press[KEY_R]) begin
                rate_fast <= ~rate_fast;
            end
            if (step) begin
                if (dir_down) begin
                    if (tone != '0) tone <= tone - tone_t'(1);
                end else if (tone < tone_t'(TONE_MAX)) begin
                    tone <= tone + tone_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== key_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_decoder (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output logic [3:0] key_held,
    output logic [3:0] key_press
);

    import kbd_pkg::*;

    logic     ext_flag;
    logic     brk_flag;
    logic     hit;
    key_idx_e idx;

    // Map a make code to its key position
    always_comb begin
        hit = 1'b1;
        idx = KEY_W;
        case (byte_data)
            SC_W:     idx = KEY_W;
            SC_S:     idx = KEY_S;
            SC_R:     idx = KEY_R;
            SC_ENTER: idx = KEY_ENTER;
            default:  hit = 1'b0;
        endcase
        if (ext_flag) begin
            hit = 1'b0; // Extended keys are never ours
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ext_flag  <= 1'b0;
            brk_flag  <= 1'b0;
            key_held  <= '0;
            key_press <= '0;
        end else begin
            key_press <= '0;
            if (byte_valid) begin
                if (byte_data == SC_BAT_OK) begin
                    // Keyboard came back from self-test
                    ext_flag <= 1'b0;
                    brk_flag <= 1'b0;
                    key_held <= '0;
                end else if (byte_data == SC_EXTEND) begin
                    ext_flag <= 1'b1;
                end else if (byte_data == SC_BREAK) begin
                    brk_flag <= 1'b1;
                end else begin
                    ext_flag <= 1'b0;
                    brk_flag <= 1'b0;
                    if (hit) begin
                        if (brk_flag) begin
                            key_held[idx] <= 1'b0;
                        end else if (!key_held[idx]) begin
                            key_held[idx]  <= 1'b1;
                            key_press[idx] <= 1'b1; // Typematic repeats skip this
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== ps2_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        fall;
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic [11:0] idle_cnt;
    logic        frame_done;
    logic        frame_ok;

    assign fall = clk_prev & ~clk_sync[1];

    // Start 0, stop 1, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync <= 2'b11; // Lines idle high
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (fall) begin
            frame <= {dat_sync[1], frame[10:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                if (idle_cnt == 12'hFFF) begin // Stalled mid-frame
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 12'd1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= frame_done & frame_ok; // Bad frames dropped here
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done) begin
            byte_data <= frame[8:1];
        end
    end

endmodule

`default_nettype wire

// ==== audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    localparam int TONE_MAX = 28; // C8

    typedef logic [4:0]  tone_t;
    typedef logic [31:0] period_t;

    // C major from C4 up, each octave doubled from the first
    localparam logic [31:0] NOTE_HZ [0:28] = '{
        32'd262,  32'd294,  32'd330,  32'd349,  32'd392,  32'd440,  32'd494,
        32'd524,  32'd588,  32'd660,  32'd698,  32'd784,  32'd880,  32'd988,
        32'd1048, 32'd1176, 32'd1320, 32'd1396, 32'd1568, 32'd1760, 32'd1976,
        32'd2096, 32'd2352, 32'd2640, 32'd2792, 32'd3136, 32'd3520, 32'd3952,
        32'd4192
    };

    // Clock cycles per wave period, truncated
    function automatic period_t note_period(
        input int unsigned clk_hz,
        input tone_t       idx
    );
        logic [31:0] hz;
        hz = NOTE_HZ[idx];
        return period_t'(clk_hz / hz);
    endfunction

endpackage

`default_nettype wire

// ==== kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

    // Set 2 make codes of the tracked keys
    localparam logic [7:0] SC_W     = 8'h1D;
    localparam logic [7:0] SC_S     = 8'h1B;
    localparam logic [7:0] SC_R     = 8'h2D;
    localparam logic [7:0] SC_ENTER = 8'h5A;

    localparam logic [7:0] SC_BREAK  = 8'hF0; // Release prefix
    localparam logic [7:0] SC_EXTEND = 8'hE0; // Extended key prefix
    localparam logic [7:0] SC_BAT_OK = 8'hAA; // Sent after keyboard self-test

    // Bit positions in the key_held and key_press vectors
    typedef enum logic [1:0] {
        KEY_W,
        KEY_S,
        KEY_R,
        KEY_ENTER
    } key_idx_e;

endpackage

`default_nettype wire
